// ==== verilog.f ====
+incdir+logic
logic/zhxpu_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/register_file.sv
logic/alu.sv
logic/data_mem_ctrl.sv
logic/execute_stage.sv
logic/zhxpu.sv
tests/zhxpu_assertions.sv
tests/zhxpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the zhxpu testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module zhxpu_tb \
	-o zhxpu_sim && { ./obj_dir/zhxpu_sim > sim.log 2>&1; cat sim.log; } || exit 1
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

// ==== tests/zhxpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module zhxpu_tb;

	localparam int WB_TIMEOUT = 50;
	localparam int HALT_TIMEOUT = 50;
	localparam int FROZEN_CYCLES = 20;

	logic clk = 1'b0;
	logic reset;
	logic boot_en;
	logic boot_we;
	zhxpu_pkg::word_t boot_addr;
	zhxpu_pkg::word_t boot_data;
	logic halted;
	logic wb_valid;
	zhxpu_pkg::reg_addr_t wb_addr;
	zhxpu_pkg::word_t wb_value;
	zhxpu_pkg::word_t pc;

	// Program table, one entry per instruction word
	zhxpu_pkg::opcode_e tbl_op [$];
	zhxpu_pkg::reg_addr_t tbl_rd [$];
	zhxpu_pkg::reg_addr_t tbl_rs [$];
	zhxpu_pkg::reg_addr_t tbl_rt [$];
	logic [8:0] tbl_imm [$];

	// Write-back trace from the reference model
	zhxpu_pkg::reg_addr_t exp_addr [$];
	zhxpu_pkg::word_t exp_value [$];

	logic [31:0] rng_state = 32'h3132b3f6;

	always #10 clk = ~clk;

	zhxpu #(
		.MEM_WAIT(2)
	) zhxpu_inst (
		.clk(clk),
		.reset(reset),
		.boot_en(boot_en),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.halted(halted),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.pc(pc)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic zhxpu_pkg::word_t sext6(input logic [5:0] v);
		return {{10{v[5]}}, v};
	endfunction

	function automatic zhxpu_pkg::word_t encode(input int idx);
		zhxpu_pkg::word_t w;
		case (tbl_op[idx])
			zhxpu_pkg::ADD, zhxpu_pkg::SUB, zhxpu_pkg::AND, zhxpu_pkg::OR:
				w = {tbl_op[idx], tbl_rd[idx], tbl_rs[idx], tbl_rt[idx], 3'b000};
			zhxpu_pkg::ADDI, zhxpu_pkg::LW, zhxpu_pkg::SW:
				w = {tbl_op[idx], tbl_rd[idx], tbl_rs[idx], tbl_imm[idx][5:0]};
			zhxpu_pkg::LI, zhxpu_pkg::BNEZ:
				w = {tbl_op[idx], tbl_rd[idx], tbl_imm[idx]};
			default:
				w = {tbl_op[idx], 12'h000};
		endcase
		return w;
	endfunction

	task automatic add_inst(input zhxpu_pkg::opcode_e op, input int rd, input int rs,
			input int rt, input int imm, input bit rnd);
		logic [8:0] field;
		field = 9'(imm);
		if (rnd) begin
			rng_state = xorshift32(rng_state);
			field = rng_state[8:0];
		end
		tbl_op.push_back(op);
		tbl_rd.push_back(zhxpu_pkg::reg_addr_t'(rd));
		tbl_rs.push_back(zhxpu_pkg::reg_addr_t'(rs));
		tbl_rt.push_back(zhxpu_pkg::reg_addr_t'(rt));
		tbl_imm.push_back(field);
	endtask

	task automatic load_program;
		add_inst(zhxpu_pkg::LI, 1, 0, 0, 0, 1);
		add_inst(zhxpu_pkg::LI, 2, 0, 0, 0, 1);
		// Dependent chain, each reads the one before it
		add_inst(zhxpu_pkg::ADD, 3, 1, 2, 0, 0);
		add_inst(zhxpu_pkg::SUB, 4, 3, 1, 0, 0);
		add_inst(zhxpu_pkg::AND, 5, 4, 2, 0, 0);
		add_inst(zhxpu_pkg::OR, 6, 5, 3, 0, 0);
		add_inst(zhxpu_pkg::ADDI, 7, 6, 0, 0, 1);
		add_inst(zhxpu_pkg::SW, 7, 1, 0, 5, 0);
		add_inst(zhxpu_pkg::LW, 2, 1, 0, 5, 0);
		add_inst(zhxpu_pkg::ADD, 3, 2, 2, 0, 0);
		add_inst(zhxpu_pkg::LI, 5, 0, 0, 3, 0);
		// Taken, lands on index 14
		add_inst(zhxpu_pkg::BNEZ, 5, 0, 0, 2, 0);
		add_inst(zhxpu_pkg::LI, 6, 0, 0, 0, 1);
		add_inst(zhxpu_pkg::ADD, 7, 1, 1, 0, 0);
		add_inst(zhxpu_pkg::SUB, 4, 4, 5, 0, 0);
		// r0 is never written so this falls through
		add_inst(zhxpu_pkg::BNEZ, 0, 0, 0, 2, 0);
		add_inst(zhxpu_pkg::OR, 1, 4, 5, 0, 0);
		add_inst(zhxpu_pkg::ADDI, 2, 1, 0, 0, 1);
		add_inst(zhxpu_pkg::HALT, 0, 0, 0, 0, 0);
		add_inst(zhxpu_pkg::LI, 3, 0, 0, 0, 1);
		add_inst(zhxpu_pkg::ADD, 4, 1, 2, 0, 0);
	endtask

	// Architectural walk of the program table
	task automatic build_expected;
		zhxpu_pkg::word_t regs [8];
		zhxpu_pkg::word_t dmem [256];
		zhxpu_pkg::word_t a;
		zhxpu_pkg::word_t addr;
		zhxpu_pkg::word_t value;
		zhxpu_pkg::reg_addr_t rd;
		logic [8:0] imm;
		int idx;
		int next;
		int steps;
		int r;
		bit running;
		bit write;
		for (r = 0; r < 8; r++) begin
			regs[r] = '0;
		end
		idx = 0;
		steps = 0;
		running = 1'b1;
		while (running && steps < 100 && idx < tbl_op.size()) begin
			rd = tbl_rd[idx];
			imm = tbl_imm[idx];
			a = regs[tbl_rs[idx]];
			addr = a + sext6(imm[5:0]);
			value = '0;
			write = 1'b1;
			next = idx + 1;
			case (tbl_op[idx])
				zhxpu_pkg::ADD: value = a + regs[tbl_rt[idx]];
				zhxpu_pkg::SUB: value = a - regs[tbl_rt[idx]];
				zhxpu_pkg::AND: value = a & regs[tbl_rt[idx]];
				zhxpu_pkg::OR: value = a | regs[tbl_rt[idx]];
				zhxpu_pkg::ADDI: value = addr;
				zhxpu_pkg::LI: value = {7'b0, imm};
				zhxpu_pkg::LW: value = dmem[addr[7:0]];
				zhxpu_pkg::SW: begin
					dmem[addr[7:0]] = regs[rd];
					write = 1'b0;
				end
				zhxpu_pkg::BNEZ: begin
					write = 1'b0;
					if (regs[rd] != '0) begin
						next = idx + 1 + int'($signed(imm));
					end
				end
				zhxpu_pkg::HALT: begin
					write = 1'b0;
					running = 1'b0;
				end
				default: write = 1'b0;
			endcase
			if (write) begin
				regs[rd] = value;
				exp_addr.push_back(rd);
				exp_value.push_back(value);
			end
			idx = next;
			steps++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_wb(input zhxpu_pkg::reg_addr_t got_addr,
			input zhxpu_pkg::word_t got_value, input zhxpu_pkg::reg_addr_t want_addr,
			input zhxpu_pkg::word_t want_value);
		if (got_addr !== want_addr || got_value !== want_value) begin
			abort_run($sformatf("mismatch at %0t: write-back expected r%0d = %h, got r%0d = %h",
				$time, want_addr, want_value, got_addr, got_value));
		end
	endtask

	task automatic check_halt(input logic got_halted, input zhxpu_pkg::word_t got_pc,
			input zhxpu_pkg::word_t want_pc);
		if (got_halted !== 1'b1) begin
			abort_run($sformatf("mismatch at %0t: halted dropped after HALT", $time));
		end
		if (got_pc !== want_pc) begin
			abort_run($sformatf("mismatch at %0t: pc moved after HALT, expected %h, got %h",
				$time, want_pc, got_pc));
		end
	endtask

	task automatic wait_for_wb;
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (wb_valid !== 1'b1 && cycles < WB_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (wb_valid !== 1'b1) begin
			abort_run($sformatf("no write-back came within %0d cycles", WB_TIMEOUT));
		end
	endtask

	task automatic wait_for_halt;
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			if (wb_valid !== 1'b0) begin
				abort_run("a write-back came after the last expected one");
			end
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			abort_run($sformatf("halted did not rise within %0d cycles", HALT_TIMEOUT));
		end
	endtask

	initial begin
		zhxpu_pkg::word_t frozen_pc;
		int i;
		reset = 1'b1;
		boot_en = 1'b1;
		boot_we = 1'b0;
		boot_addr = '0;
		boot_data = '0;
		load_program;
		build_expected;

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (halted !== 1'b0 || wb_valid !== 1'b0) begin
			abort_run("core was not idle after reset");
		end

		// Boot port writes the program into instruction memory
		for (i = 0; i < tbl_op.size(); i++) begin
			@(posedge clk);
			boot_we <= 1'b1;
			boot_addr <= zhxpu_pkg::word_t'(i);
			boot_data <= encode(i);
			@(negedge clk);
			if (wb_valid !== 1'b0) begin
				abort_run("write-back seen while booting");
			end
		end
		@(posedge clk);
		boot_we <= 1'b0;
		boot_en <= 1'b0;

		for (i = 0; i < exp_addr.size(); i++) begin
			wait_for_wb;
			check_wb(wb_addr, wb_value, exp_addr[i], exp_value[i]);
		end

		wait_for_halt;
		frozen_pc = pc;
		repeat (FROZEN_CYCLES) begin
			@(negedge clk);
			if (wb_valid !== 1'b0) begin
				abort_run("a write-back came after HALT");
			end
			check_halt(halted, pc, frozen_pc);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/zhxpu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module zhxpu_assertions (
	input wire clk,
	input wire reset,
	input wire need_to_work,
	input wire work_done,
	input wire mem_we,
	input wire zhxpu_pkg::word_t mem_addr,
	input wire zhxpu_pkg::word_t mem_wdata,
	input wire ex_valid,
	input wire zhxpu_pkg::opcode_e ex_opcode,
	input wire halted,
	input wire wb_valid
);

	done_needs_request: assert property (
		@(posedge clk) disable iff (reset)
		work_done |-> need_to_work
	) else $error("work_done high without need_to_work");

	// Request and its data hold until the controller answers
	request_stable: assert property (
		@(posedge clk) disable iff (reset)
		(need_to_work && !work_done) |=> (need_to_work && $stable(mem_we)
			&& $stable(mem_addr) && $stable(mem_wdata))
	) else $error("memory request changed before work_done");

	// HALT in EXE stops the core for good
	no_wb_after_halt: assert property (
		@(posedge clk) disable iff (reset)
		(ex_valid && ex_opcode == zhxpu_pkg::HALT) |=> (halted && !wb_valid)
	) else $error("write-back or no halt after HALT reached EXE");

endmodule

bind execute_stage zhxpu_assertions zhxpu_assertions_inst (
	.clk(clk),
	.reset(reset),
	.need_to_work(need_to_work),
	.work_done(work_done),
	.mem_we(mem_we),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.ex_valid(ex_valid),
	.ex_opcode(ex_opcode),
	.halted(halted),
	.wb_valid(wb_valid)
);

`default_nettype wire

// ==== logic/zhxpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module zhxpu #(
	parameter int MEM_WAIT = 2
) (
	input wire clk,
	input wire reset,
	input wire boot_en,
	input wire boot_we,
	input wire zhxpu_pkg::word_t boot_addr,
	input wire zhxpu_pkg::word_t boot_data,
	output logic halted,
	output logic wb_valid,
	output zhxpu_pkg::reg_addr_t wb_addr,
	output zhxpu_pkg::word_t wb_value,
	output zhxpu_pkg::word_t pc
);
	// IF/ID
	zhxpu_pkg::word_t id_pc;
	zhxpu_pkg::word_t id_inst;
	wire id_valid;

	// Decode
	zhxpu_pkg::opcode_e opcode;
	zhxpu_pkg::reg_addr_t rd;
	zhxpu_pkg::reg_addr_t rs;
	zhxpu_pkg::reg_addr_t rt;
	zhxpu_pkg::word_t imm;
	wire reg_write;
	wire mem_read;
	wire mem_write;
	wire is_branch;
	zhxpu_pkg::word_t read_value1;
	zhxpu_pkg::word_t read_value2;

	// Pipeline control
	wire hold;
	wire redirect;
	zhxpu_pkg::word_t redirect_pc;

	// Data memory handshake
	wire need_to_work;
	wire work_done;
	wire mem_we;
	zhxpu_pkg::word_t mem_addr;
	zhxpu_pkg::word_t mem_wdata;
	zhxpu_pkg::word_t mem_rdata;

	assign pc = id_pc;

	fetch_stage fetch_stage_inst (
		.clk(clk),
		.reset(reset),
		.boot_en(boot_en),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.hold(hold),
		.halted(halted),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.id_pc(id_pc),
		.id_inst(id_inst),
		.id_valid(id_valid)
	);

	decoder decoder_inst (
		.inst(id_inst),
		.opcode(opcode),
		.rd(rd),
		.rs(rs),
		.rt(rt),
		.imm(imm),
		.reg_write(reg_write),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.is_branch(is_branch)
	);

	register_file register_file_inst (
		.clk(clk),
		.reset(reset),
		.read_addr1(rs),
		.read_addr2(rt),
		.read_value1(read_value1),
		.read_value2(read_value2),
		.write_en(wb_valid),
		.write_addr(wb_addr),
		.write_value(wb_value)
	);

	execute_stage execute_stage_inst (
		.clk(clk),
		.reset(reset),
		.boot_en(boot_en),
		.id_valid(id_valid),
		.id_pc(id_pc),
		.opcode(opcode),
		.rd(rd),
		.imm(imm),
		.reg_write(reg_write),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.is_branch(is_branch),
		.read_value1(read_value1),
		.read_value2(read_value2),
		.need_to_work(need_to_work),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.work_done(work_done),
		.mem_rdata(mem_rdata),
		.hold(hold),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halted(halted),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

	data_mem_ctrl #(
		.MEM_WAIT(MEM_WAIT)
	) data_mem_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.need_to_work(need_to_work),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.work_done(work_done),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input wire clk,
	input wire reset,
	input wire boot_en,
	input wire id_valid,
	input wire zhxpu_pkg::word_t id_pc,
	input wire zhxpu_pkg::opcode_e opcode,
	input wire zhxpu_pkg::reg_addr_t rd,
	input wire zhxpu_pkg::word_t imm,
	input wire reg_write,
	input wire mem_read,
	input wire mem_write,
	input wire is_branch,
	input wire zhxpu_pkg::word_t read_value1,
	input wire zhxpu_pkg::word_t read_value2,
	output logic need_to_work,
	output logic mem_we,
	output zhxpu_pkg::word_t mem_addr,
	output zhxpu_pkg::word_t mem_wdata,
	input wire work_done,
	input wire zhxpu_pkg::word_t mem_rdata,
	output logic hold,
	output logic redirect,
	output zhxpu_pkg::word_t redirect_pc,
	output logic halted,
	output logic wb_valid,
	output zhxpu_pkg::reg_addr_t wb_addr,
	output zhxpu_pkg::word_t wb_value
);
	zhxpu_pkg::opcode_e ex_opcode;
	zhxpu_pkg::reg_addr_t ex_rd;
	zhxpu_pkg::word_t ex_pc;
	zhxpu_pkg::word_t ex_imm;
	zhxpu_pkg::word_t ex_value1;
	zhxpu_pkg::word_t ex_value2;
	logic ex_valid;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_is_branch;
	logic req_gap;
	logic active;
	logic mem_op;
	zhxpu_pkg::word_t alu_op2;
	zhxpu_pkg::word_t alu_res;
	logic alu_zero;

	// ID/EXE register
	always_ff @(posedge clk) begin
		if (reset || boot_en || redirect) begin
			ex_valid <= 1'b0;
		end else if (!hold) begin
			ex_valid <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			ex_opcode <= opcode;
			ex_rd <= rd;
			ex_pc <= id_pc;
			ex_imm <= imm;
			ex_value1 <= read_value1;
			ex_value2 <= read_value2;
			ex_reg_write <= reg_write;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
			ex_is_branch <= is_branch;
		end
	end

	// req_gap forces need_to_work low for a cycle between accesses
	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
			req_gap <= 1'b0;
		end else begin
			req_gap <= work_done;
			if (active && ex_opcode == zhxpu_pkg::HALT) begin
				halted <= 1'b1;
			end
		end
	end

	assign active = ex_valid && !halted;
	assign mem_op = active && (ex_mem_read || ex_mem_write);

	always_comb begin
		case (ex_opcode)
			zhxpu_pkg::ADD, zhxpu_pkg::SUB, zhxpu_pkg::AND, zhxpu_pkg::OR: begin
				alu_op2 = ex_value2;
			end
			default: begin
				alu_op2 = ex_imm;
			end
		endcase
	end

	alu alu_inst (
		.opcode(ex_opcode),
		.op1(ex_value1),
		.op2(alu_op2),
		.res(alu_res),
		.zero(alu_zero)
	);

	assign need_to_work = mem_op && !req_gap;
	assign mem_we = ex_mem_write;
	assign mem_addr = alu_res;
	assign mem_wdata = ex_value2;
	assign hold = mem_op && !work_done;

	// Branch taken when the tested register is nonzero
	assign redirect = active && ex_is_branch && !alu_zero;
	assign redirect_pc = ex_pc + ex_imm + zhxpu_pkg::word_t'(1);

	assign wb_valid = active && ex_reg_write && (!ex_mem_read || work_done);
	assign wb_addr = ex_rd;
	assign wb_value = ex_mem_read ? mem_rdata : alu_res;

endmodule

`default_nettype wire

// ==== logic/data_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module data_mem_ctrl #(
	parameter int MEM_WAIT = 2
) (
	input wire clk,
	input wire reset,
	input wire need_to_work,
	input wire mem_we,
	input wire zhxpu_pkg::word_t mem_addr,
	input wire zhxpu_pkg::word_t mem_wdata,
	output logic work_done,
	output zhxpu_pkg::word_t mem_rdata
);
	localparam int DMEM_AW = $clog2(`ZHXPU_DMEM_DEPTH);
	localparam logic [2:0] WAIT_LAST = 3'(MEM_WAIT);

	zhxpu_pkg::word_t dmem [`ZHXPU_DMEM_DEPTH];
	zhxpu_pkg::mem_state_e state;
	logic [2:0] wait_cnt;
	logic [DMEM_AW-1:0] word_addr;

	assign word_addr = mem_addr[DMEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= zhxpu_pkg::IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				zhxpu_pkg::IDLE: begin
					if (need_to_work) begin
						wait_cnt <= 3'd1;
						if (MEM_WAIT == 0) begin
							state <= zhxpu_pkg::DONE;
						end else begin
							state <= zhxpu_pkg::WAIT;
						end
					end
				end
				zhxpu_pkg::WAIT: begin
					if (wait_cnt == WAIT_LAST) begin
						state <= zhxpu_pkg::DONE;
					end else begin
						wait_cnt <= wait_cnt + 3'd1;
					end
				end
				default: begin
					state <= zhxpu_pkg::IDLE;
				end
			endcase
		end
	end

	// Access lands in the DONE cycle
	always_ff @(posedge clk) begin
		if (state == zhxpu_pkg::DONE && mem_we) begin
			dmem[word_addr] <= mem_wdata;
		end
	end

	assign work_done = (state == zhxpu_pkg::DONE);
	assign mem_rdata = dmem[word_addr];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire zhxpu_pkg::opcode_e opcode,
	input wire zhxpu_pkg::word_t op1,
	input wire zhxpu_pkg::word_t op2,
	output zhxpu_pkg::word_t res,
	output logic zero
);
	always_comb begin
		case (opcode)
			// Loads and stores add their offset here too
			zhxpu_pkg::ADD, zhxpu_pkg::ADDI, zhxpu_pkg::LW, zhxpu_pkg::SW: begin
				res = op1 + op2;
			end
			zhxpu_pkg::SUB: begin
				res = op1 - op2;
			end
			zhxpu_pkg::AND: begin
				res = op1 & op2;
			end
			zhxpu_pkg::OR: begin
				res = op1 | op2;
			end
			zhxpu_pkg::LI: begin
				res = op2;
			end
			default: begin
				res = '0;
			end
		endcase
	end

	assign zero = (op1 == '0);

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module register_file (
	input wire clk,
	input wire reset,
	input wire zhxpu_pkg::reg_addr_t read_addr1,
	input wire zhxpu_pkg::reg_addr_t read_addr2,
	output zhxpu_pkg::word_t read_value1,
	output zhxpu_pkg::word_t read_value2,
	input wire write_en,
	input wire zhxpu_pkg::reg_addr_t write_addr,
	input wire zhxpu_pkg::word_t write_value
);
	zhxpu_pkg::word_t regs [`ZHXPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ZHXPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_value;
		end
	end

	// Write-through so the next instruction sees this cycle's result
	assign read_value1 = (write_en && write_addr == read_addr1) ? write_value : regs[read_addr1];
	assign read_value2 = (write_en && write_addr == read_addr2) ? write_value : regs[read_addr2];

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire zhxpu_pkg::word_t inst,
	output zhxpu_pkg::opcode_e opcode,
	output zhxpu_pkg::reg_addr_t rd,
	output zhxpu_pkg::reg_addr_t rs,
	output zhxpu_pkg::reg_addr_t rt,
	output zhxpu_pkg::word_t imm,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic is_branch
);
	zhxpu_pkg::word_t imm6_sext;
	zhxpu_pkg::word_t imm9_sext;
	zhxpu_pkg::word_t imm9_zext;

	assign imm6_sext = zhxpu_pkg::word_t'($signed(inst[5:0]));
	assign imm9_sext = zhxpu_pkg::word_t'($signed(inst[8:0]));
	assign imm9_zext = zhxpu_pkg::word_t'(inst[8:0]);

	always_comb begin
		opcode = zhxpu_pkg::NOP;
		rd = inst[11:9];
		rs = inst[8:6];
		rt = inst[5:3];
		imm = '0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		case (inst[15:12])
			zhxpu_pkg::ADD, zhxpu_pkg::SUB, zhxpu_pkg::AND, zhxpu_pkg::OR: begin
				opcode = zhxpu_pkg::opcode_e'(inst[15:12]);
				reg_write = 1'b1;
			end
			zhxpu_pkg::ADDI: begin
				opcode = zhxpu_pkg::ADDI;
				imm = imm6_sext;
				reg_write = 1'b1;
			end
			zhxpu_pkg::LI: begin
				opcode = zhxpu_pkg::LI;
				imm = imm9_zext;
				reg_write = 1'b1;
			end
			zhxpu_pkg::LW: begin
				opcode = zhxpu_pkg::LW;
				imm = imm6_sext;
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			zhxpu_pkg::SW: begin
				opcode = zhxpu_pkg::SW;
				imm = imm6_sext;
				mem_write = 1'b1;
				// Store data comes from rd on the second read port
				rt = inst[11:9];
			end
			zhxpu_pkg::BNEZ: begin
				opcode = zhxpu_pkg::BNEZ;
				imm = imm9_sext;
				is_branch = 1'b1;
				// Tested register goes out as op1
				rs = inst[11:9];
			end
			zhxpu_pkg::HALT: begin
				opcode = zhxpu_pkg::HALT;
			end
			default: begin
				opcode = zhxpu_pkg::NOP;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module fetch_stage (
	input wire clk,
	input wire reset,
	input wire boot_en,
	input wire boot_we,
	input wire zhxpu_pkg::word_t boot_addr,
	input wire zhxpu_pkg::word_t boot_data,
	input wire hold,
	input wire halted,
	input wire redirect,
	input wire zhxpu_pkg::word_t redirect_pc,
	output zhxpu_pkg::word_t id_pc,
	output zhxpu_pkg::word_t id_inst,
	output logic id_valid
);
	localparam int IMEM_AW = $clog2(`ZHXPU_IMEM_DEPTH);

	zhxpu_pkg::word_t imem [`ZHXPU_IMEM_DEPTH];
	zhxpu_pkg::word_t pc;
	zhxpu_pkg::word_t if_inst;
	logic freeze;

	assign if_inst = imem[pc[IMEM_AW-1:0]];
	// Nothing moves after HALT
	assign freeze = hold || halted;

	always_ff @(posedge clk) begin
		if (boot_en && boot_we) begin
			imem[boot_addr[IMEM_AW-1:0]] <= boot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || boot_en) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!freeze) begin
			pc <= pc + zhxpu_pkg::word_t'(1);
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (reset || boot_en || redirect) begin
			id_valid <= 1'b0;
		end else if (!freeze) begin
			id_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			id_pc <= pc;
			id_inst <= if_inst;
		end
	end

endmodule

`default_nettype wire

// ==== logic/zhxpu_pkg.sv ====
`default_nettype none
`include "zhxpu_params.svh"

package zhxpu_pkg;

	typedef logic [`ZHXPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`ZHXPU_REG_COUNT)-1:0] reg_addr_t;

	// Instruction bits 15:12
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		ADDI = 4'd5,
		LI   = 4'd6,
		LW   = 4'd7,
		SW   = 4'd8,
		BNEZ = 4'd9,
		HALT = 4'd10
	} opcode_e;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		DONE
	} mem_state_e;

endpackage

`default_nettype wire

// ==== logic/zhxpu_params.svh ====
`ifndef ZHXPU_PARAMS_SVH
`define ZHXPU_PARAMS_SVH

// Datapath width, shared by instructions, registers and data
`define ZHXPU_WORD_W 16

// General purpose registers
`define ZHXPU_REG_COUNT 8

// Memory sizes in words
`define ZHXPU_IMEM_DEPTH 256
`define ZHXPU_DMEM_DEPTH 256

`endif
